// ==== common/ibuf_consts.svh ====
// input buffer receive constants
// buffer geometry, tag space and completion field codes

`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

// input buffer ring
`define IBUF_AW       9             // 512 quadword slots

// read tags and request limits
`define TAG_W         2
`define NUM_TAGS      4
`define MAX_OS_REQ    4             // outstanding reads

`define HOST_AW       64

// completion tlp fields
`define CPL_FMT_TYPE  7'b10_01010   // cpld, 3dw header with data
`define CPL_SC        3'b000        // successful completion

`endif

// ==== common/ibuf_pkg.sv ====
// shared types for the input buffer receive path
// ring pointers, lengths and the two views of a completion header beat

`default_nettype none

`include "ibuf_consts.svh"

package ibuf_pkg;

    typedef logic [`IBUF_AW-1:0] ibuf_addr_t;   // quadword slot
    typedef logic [`IBUF_AW:0]   ibuf_ptr_t;    // extra wrap bit
    typedef logic [7:0]          req_len_t;     // up to 128 qw
    typedef logic [9:0]          dw_len_t;
    typedef logic [`TAG_W-1:0]   tag_t;

    // beat 0, dword 1 in the high half
    typedef struct packed {
        logic [15:0] cpl_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_cnt;
        logic        rsvd;
        logic [6:0]  fmt_type;
        logic [13:0] attr_tc;       // tc, td, ep, attr bits
        dw_len_t     length;
    } cpl_hdr0_t;

    // beat 1, first payload dword rides in the high half
    typedef struct packed {
        logic [31:0] payload;
        logic [15:0] req_id;
        logic [7:0]  tag;
        logic        rsvd;
        logic [6:0]  lower_addr;
    } cpl_hdr1_t;

    typedef union packed {
        logic [63:0] raw;
        cpl_hdr0_t   h0;
        cpl_hdr1_t   h1;
    } cpl_beat_u;

endpackage

`default_nettype wire

// ==== common/req_if.sv ====
// read request announcement
// one pulse per read accepted by the host, seen by every tracking block

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

interface req_if;

    logic                 issue;    // rd_ack seen
    ibuf_pkg::tag_t       tag;
    ibuf_pkg::ibuf_addr_t base;     // slot of the first quadword
    ibuf_pkg::req_len_t   qw_len;

    modport issuer (
        output issue,
        output tag,
        output base,
        output qw_len
    );

    modport tracker (
        input issue,
        input tag,
        input base,
        input qw_len
    );

endinterface

`default_nettype wire

// ==== common/cpl_stream_if.sv ====
// filtered completion payload stream
// one or two dwords per beat, a lone dword always in the low half

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

interface cpl_stream_if;

    logic           valid;
    logic           sop;
    logic           eop;
    ibuf_pkg::tag_t tag;
    logic [63:0]    dw;
    logic [1:0]     dw_cnt;     // 1 or 2

    modport source (
        output valid,
        output sop,
        output eop,
        output tag,
        output dw,
        output dw_cnt
    );

    modport sink (
        input valid,
        input sop,
        input eop,
        input tag,
        input dw,
        input dw_cnt
    );

endinterface

`default_nettype wire

// ==== source/rd_req_gen.sv ====
// read request generator
// walks a buffer descriptor in max read request chunks, bounded by ring
// space and by the number of outstanding reads

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module rd_req_gen (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [2:0]                cfg_max_rd_req_size,
    input  wire                      lbuf_req,
    input  wire [`HOST_AW-1:0]       lbuf_addr,
    input  wire [31:0]               lbuf_len,
    output logic                     lbuf_ack,
    output logic                     rd,
    output logic [`HOST_AW-1:0]      hst_addr,
    output ibuf_pkg::req_len_t       rd_qw,
    input  wire                      rd_ack,
    input  wire ibuf_pkg::tag_t      rd_tag,
    input  wire ibuf_pkg::ibuf_ptr_t committed_cons,
    input  wire                      retire,
    req_if.issuer                    req
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_CHECK = 3'd1;
    localparam logic [2:0] S_REQ   = 3'd2;
    localparam logic [2:0] S_DROP  = 3'd3;   // wait for rd_ack low
    localparam logic [2:0] S_ACK   = 3'd4;

    logic [2:0]          state;
    logic [31:0]         rem_qw;            // still to request
    ibuf_pkg::ibuf_ptr_t iprod;             // issued pointer
    logic [2:0]          os_cnt;
    ibuf_pkg::req_len_t  max_qw;
    ibuf_pkg::req_len_t  chunk;
    ibuf_pkg::ibuf_ptr_t used;
    logic                room;

    always_comb begin
        case (cfg_max_rd_req_size)
            3'd0:    max_qw = 8'd16;
            3'd1:    max_qw = 8'd32;
            3'd2:    max_qw = 8'd64;
            default: max_qw = 8'd128;
        endcase
    end

    assign chunk = (rem_qw < 32'(max_qw)) ? rem_qw[7:0] : max_qw;
    assign used  = iprod - committed_cons;  // issued, not yet consumed
    assign room  = ({1'b0, used} + 11'(chunk) <= 11'(1 << `IBUF_AW))
                   && (os_cnt < `MAX_OS_REQ);

    assign req.issue  = (state == S_REQ) && rd_ack;
    assign req.tag    = rd_tag;
    assign req.base   = iprod[`IBUF_AW-1:0];
    assign req.qw_len = rd_qw;

    ////////////////////////////////////////
    // descriptor walk
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            rd       <= 1'b0;
            lbuf_ack <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    hst_addr <= lbuf_addr;
                    rem_qw   <= lbuf_len;
                    if (lbuf_req) begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (rem_qw == 32'd0) begin
                        lbuf_ack <= 1'b1;
                        state    <= S_ACK;
                    end else if (room) begin
                        rd    <= 1'b1;
                        rd_qw <= chunk;
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (rd_ack) begin
                        rd       <= 1'b0;
                        hst_addr <= hst_addr + (`HOST_AW'(rd_qw) << 3);
                        rem_qw   <= rem_qw - 32'(rd_qw);
                        state    <= S_DROP;
                    end
                end
                S_DROP: begin
                    if (!rd_ack) begin
                        state <= S_CHECK;
                    end
                end
                S_ACK: begin
                    if (!lbuf_req) begin
                        lbuf_ack <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iprod  <= '0;
            os_cnt <= '0;
        end else begin
            if (req.issue) begin
                iprod <= iprod + rd_qw;
            end
            os_cnt <= os_cnt + 3'(req.issue) - 3'(retire);   // retire frees a slot
        end
    end

    a_rd_held: assert property (@(posedge clk) disable iff (rst)
        rd && !rd_ack |=> rd);

    a_os_limit: assert property (@(posedge clk) disable iff (rst)
        os_cnt <= `MAX_OS_REQ);

endmodule

`default_nettype wire

// ==== source/cpl_filter.sv ====
// completion filter
// keeps successful completions with data for expected tags and strips
// their headers, two cycles from rx beat to stream beat

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module cpl_filter (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [63:0]          rx_data,
    input  wire                 rx_valid,
    input  wire                 rx_sof,
    input  wire                 rx_eof,
    req_if.tracker              req,
    input  wire                 retire,
    input  wire ibuf_pkg::tag_t retire_tag,
    cpl_stream_if.source        cpl
);

    localparam logic [1:0] P_HDR0 = 2'd0;
    localparam logic [1:0] P_HDR1 = 2'd1;
    localparam logic [1:0] P_DATA = 2'd2;

    ibuf_pkg::cpl_beat_u  beat;
    logic                 b_valid;
    logic                 b_sof;
    logic                 b_eof;
    logic [1:0]           phase;
    logic [`NUM_TAGS-1:0] expected;
    logic                 hdr_ok;           // type and status passed
    logic                 len_odd;
    logic                 keep;             // tlp being forwarded
    ibuf_pkg::tag_t       cur_tag;
    logic                 tag_ok;

    assign tag_ok = (beat.h1.tag[7:`TAG_W] == '0) && expected[beat.h1.tag[`TAG_W-1:0]];

    always_ff @(posedge clk) begin
        beat.raw <= rx_data;
        b_sof    <= rx_sof;
        b_eof    <= rx_eof;
        if (rst) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= rx_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            expected <= '0;
        end else begin
            if (retire) begin
                expected[retire_tag] <= 1'b0;
            end
            if (req.issue) begin
                expected[req.tag] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // header decode and payload strip
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= P_HDR0;
            keep      <= 1'b0;
            cpl.valid <= 1'b0;
        end else begin
            cpl.valid <= 1'b0;
            if (b_valid && b_sof) begin
                hdr_ok  <= (beat.h0.fmt_type == `CPL_FMT_TYPE) && (beat.h0.status == `CPL_SC);
                len_odd <= beat.h0.length[0];
                keep    <= 1'b0;
                phase   <= P_HDR1;
            end else if (b_valid) begin
                case (phase)
                    P_HDR1: begin
                        keep       <= hdr_ok && tag_ok;
                        cur_tag    <= beat.h1.tag[`TAG_W-1:0];
                        cpl.valid  <= hdr_ok && tag_ok;
                        cpl.sop    <= 1'b1;
                        cpl.eop    <= b_eof;
                        cpl.tag    <= beat.h1.tag[`TAG_W-1:0];
                        cpl.dw     <= {32'h0, beat.h1.payload};
                        cpl.dw_cnt <= 2'd1;
                        phase      <= b_eof ? P_HDR0 : P_DATA;
                    end
                    P_DATA: begin
                        cpl.valid  <= keep;
                        cpl.sop    <= 1'b0;
                        cpl.eop    <= b_eof;
                        cpl.tag    <= cur_tag;
                        cpl.dw     <= beat.raw;
                        // even length leaves one dword for the last beat
                        cpl.dw_cnt <= (b_eof && !len_odd) ? 2'd1 : 2'd2;
                        if (b_eof) begin
                            phase <= P_HDR0;
                        end
                    end
                    default: phase <= P_HDR0;    // stray beat outside a tlp
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpl_write/cpl_writer.sv ====
// completion writer
// pairs payload dwords into quadwords per tag, carrying an odd dword
// across completions, and reports each fully received request

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module cpl_writer (
    input  wire                  clk,
    input  wire                  rst,
    req_if.tracker               req,
    cpl_stream_if.sink           cpl,
    output logic                 wr_en,
    output ibuf_pkg::ibuf_addr_t wr_addr,
    output logic [63:0]          wr_data,
    output logic                 done,
    output ibuf_pkg::tag_t       done_tag
);

    // per tag state, loaded on issue and saved at each eop
    ibuf_pkg::ibuf_addr_t t_addr [`NUM_TAGS];
    ibuf_pkg::req_len_t   t_cnt  [`NUM_TAGS];
    ibuf_pkg::req_len_t   t_len  [`NUM_TAGS];
    logic [31:0]          t_sdw  [`NUM_TAGS];
    logic [`NUM_TAGS-1:0] t_sv;
    logic [`NUM_TAGS-1:0] live;

    // working copy for the completion in flight
    ibuf_pkg::ibuf_addr_t w_addr;
    ibuf_pkg::req_len_t   w_cnt;
    logic [31:0]          w_sdw;
    logic                 w_sv;

    ibuf_pkg::ibuf_addr_t cur_addr;
    ibuf_pkg::req_len_t   cur_cnt;
    logic [31:0]          cur_sdw;
    logic                 cur_sv;
    logic                 qw_out;           // beat closes a quadword
    ibuf_pkg::ibuf_addr_t nxt_addr;
    ibuf_pkg::req_len_t   nxt_cnt;
    logic [31:0]          nxt_sdw;
    logic                 nxt_sv;

    always_comb begin
        if (cpl.sop) begin
            cur_addr = t_addr[cpl.tag];
            cur_cnt  = t_cnt[cpl.tag];
            cur_sdw  = t_sdw[cpl.tag];
            cur_sv   = t_sv[cpl.tag];
        end else begin
            cur_addr = w_addr;
            cur_cnt  = w_cnt;
            cur_sdw  = w_sdw;
            cur_sv   = w_sv;
        end
        qw_out   = (cpl.dw_cnt == 2'd2) || cur_sv;
        nxt_sv   = cur_sv ^ (cpl.dw_cnt == 2'd1);
        nxt_sdw  = cur_sv ? cpl.dw[63:32] : cpl.dw[31:0];
        nxt_addr = cur_addr + `IBUF_AW'(qw_out);
        nxt_cnt  = cur_cnt + 8'(qw_out);
    end

    ////////////////////////////////////////
    // realignment and buffer write
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req.issue) begin
            t_addr[req.tag] <= req.base;
            t_cnt[req.tag]  <= '0;
            t_len[req.tag]  <= req.qw_len;
            t_sv[req.tag]   <= 1'b0;
        end
        if (cpl.valid) begin
            w_addr  <= nxt_addr;
            w_cnt   <= nxt_cnt;
            w_sdw   <= nxt_sdw;
            w_sv    <= nxt_sv;
            wr_addr <= cur_addr;
            wr_data <= cur_sv ? {cpl.dw[31:0], cur_sdw} : cpl.dw;   // saved dword goes low
            if (cpl.eop) begin
                t_addr[cpl.tag] <= nxt_addr;
                t_cnt[cpl.tag]  <= nxt_cnt;
                t_sdw[cpl.tag]  <= nxt_sdw;
                t_sv[cpl.tag]   <= nxt_sv;
            end
        end
        done_tag <= cpl.tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
            done  <= 1'b0;
            live  <= '0;
        end else begin
            wr_en <= cpl.valid && qw_out;
            done  <= cpl.valid && qw_out && (nxt_cnt == t_len[cpl.tag]);
            if (done) begin
                live[done_tag] <= 1'b0;
            end
            if (req.issue) begin
                live[req.tag] <= 1'b1;
            end
        end
    end

    // filter must only pass tags with a request in flight
    a_tag_live: assert property (@(posedge clk) disable iff (rst)
        cpl.valid |-> live[cpl.tag]);

endmodule

`default_nettype wire

// ==== source/cpl_order.sv ====
// completion ordering
// retires requests in issue order once fully received and advances the
// committed producer pointer

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module cpl_order (
    input  wire                 clk,
    input  wire                 rst,
    req_if.tracker              req,
    input  wire                 done,
    input  wire ibuf_pkg::tag_t done_tag,
    output ibuf_pkg::ibuf_ptr_t committed_prod,
    output logic                retire,
    output ibuf_pkg::tag_t      retire_tag
);

    localparam int QW = $clog2(`MAX_OS_REQ);

    ibuf_pkg::tag_t       q_tag [`MAX_OS_REQ];
    ibuf_pkg::req_len_t   q_len [`MAX_OS_REQ];
    logic [QW:0]          wp;
    logic [QW:0]          rp;
    logic [`NUM_TAGS-1:0] rcvd;             // done seen, not yet retired
    logic [`NUM_TAGS-1:0] armed;            // issued, done still due
    ibuf_pkg::tag_t       head_tag;
    logic                 head_ok;

    assign head_tag = q_tag[rp[QW-1:0]];
    assign head_ok  = (wp != rp) && rcvd[head_tag];

    always_ff @(posedge clk) begin
        if (req.issue) begin
            q_tag[wp[QW-1:0]] <= req.tag;
            q_len[wp[QW-1:0]] <= req.qw_len;
        end
        retire_tag <= head_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wp             <= '0;
            rp             <= '0;
            rcvd           <= '0;
            armed          <= '0;
            retire         <= 1'b0;
            committed_prod <= '0;
        end else begin
            retire <= head_ok;
            if (req.issue) begin
                wp             <= wp + 1'b1;
                armed[req.tag] <= 1'b1;
            end
            if (done) begin
                rcvd[done_tag]  <= 1'b1;
                armed[done_tag] <= 1'b0;
            end
            if (head_ok) begin
                rp             <= rp + 1'b1;
                rcvd[head_tag] <= 1'b0;
                committed_prod <= committed_prod + q_len[rp[QW-1:0]];
            end
        end
    end

    a_done_once: assert property (@(posedge clk) disable iff (rst)
        done |-> armed[done_tag]);

endmodule

`default_nettype wire

// ==== source/ibuf_rx.sv ====
// input buffer receive top level
// read request generation, completion filter, writer and in-order commit

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module ibuf_rx (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [2:0]                cfg_max_rd_req_size,
    // descriptor
    input  wire                      lbuf_req,
    input  wire [`HOST_AW-1:0]       lbuf_addr,
    input  wire [31:0]               lbuf_len,
    output logic                     lbuf_ack,
    // host reads
    output logic                     rd,
    output logic [`HOST_AW-1:0]      hst_addr,
    output ibuf_pkg::req_len_t       rd_qw,
    input  wire                      rd_ack,
    input  wire ibuf_pkg::tag_t      rd_tag,
    // completion tlps
    input  wire [63:0]               rx_data,
    input  wire                      rx_valid,
    input  wire                      rx_sof,
    input  wire                      rx_eof,
    // ring pointers
    input  wire ibuf_pkg::ibuf_ptr_t committed_cons,
    output ibuf_pkg::ibuf_ptr_t      committed_prod,
    // buffer write port
    output logic                     wr_en,
    output ibuf_pkg::ibuf_addr_t     wr_addr,
    output logic [63:0]              wr_data
);

    req_if        u_req ();
    cpl_stream_if u_cpl ();

    logic           done;
    ibuf_pkg::tag_t done_tag;
    logic           retire;
    ibuf_pkg::tag_t retire_tag;

    rd_req_gen u_rd_req_gen (
        .clk                (clk),
        .rst                (rst),
        .cfg_max_rd_req_size(cfg_max_rd_req_size),
        .lbuf_req           (lbuf_req),
        .lbuf_addr          (lbuf_addr),
        .lbuf_len           (lbuf_len),
        .lbuf_ack           (lbuf_ack),
        .rd                 (rd),
        .hst_addr           (hst_addr),
        .rd_qw              (rd_qw),
        .rd_ack             (rd_ack),
        .rd_tag             (rd_tag),
        .committed_cons     (committed_cons),
        .retire             (retire),
        .req                (u_req.issuer)
    );

    cpl_filter u_cpl_filter (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_sof    (rx_sof),
        .rx_eof    (rx_eof),
        .req       (u_req.tracker),
        .retire    (retire),
        .retire_tag(retire_tag),
        .cpl       (u_cpl.source)
    );

    cpl_writer u_cpl_writer (
        .clk     (clk),
        .rst     (rst),
        .req     (u_req.tracker),
        .cpl     (u_cpl.sink),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .done    (done),
        .done_tag(done_tag)
    );

    cpl_order u_cpl_order (
        .clk           (clk),
        .rst           (rst),
        .req           (u_req.tracker),
        .done          (done),
        .done_tag      (done_tag),
        .committed_prod(committed_prod),
        .retire        (retire),
        .retire_tag    (retire_tag)
    );

endmodule

`default_nettype wire

// ==== dv/tb_ibuf_rx.sv ====
// testbench for the input buffer receive path
// host model answers reads with split completions, scoreboard checks writes and commits

`timescale 1ns/1ps
`default_nettype none

`include "ibuf_consts.svh"

module tb_ibuf_rx;

    localparam int NDESC = 6;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [2:0] cfg;
    logic lbuf_req;
    logic [63:0] lbuf_addr;
    logic [31:0] lbuf_len;
    logic rd_ack;
    ibuf_pkg::tag_t rd_tag;
    logic [63:0] rx_data;
    logic rx_valid;
    logic rx_sof;
    logic rx_eof;
    ibuf_pkg::ibuf_ptr_t cons;
    wire lbuf_ack;
    wire rd;
    wire wr_en;
    wire [63:0] hst_addr;
    wire [63:0] wr_data;
    ibuf_pkg::req_len_t rd_qw;
    ibuf_pkg::ibuf_ptr_t committed_prod;
    ibuf_pkg::ibuf_addr_t wr_addr;

    integer seed = 28;
    int mism_cnt = 0;
    int fail_cnt = 0;
    logic [63:0] exp_mem [512];     // expected buffer contents
    bit pend [512];                 // slot issued, write still due
    ibuf_pkg::ibuf_ptr_t iprod_m = '0;
    ibuf_pkg::ibuf_ptr_t prod_seen = '0;
    int os_tag [$];                 // requests in issue order
    int os_len [$];
    int os_base [$];
    bit busy [4];
    logic [63:0] c_addr [4];        // next host byte address per tag
    int c_rem [4];                  // dwords still to return
    int shun_tag = -1;              // free tag carried by a stray tlp
    logic [63:0] desc_addr_m;
    int desc_rem;
    bit hold = 1'b0;
    bit plan_ready = 1'b0;
    longint limit_ns;

    always #4 clk = ~clk;

    ibuf_rx u_dut (
        .clk(clk), .rst(rst), .cfg_max_rd_req_size(cfg),
        .lbuf_req(lbuf_req), .lbuf_addr(lbuf_addr), .lbuf_len(lbuf_len), .lbuf_ack(lbuf_ack),
        .rd(rd), .hst_addr(hst_addr), .rd_qw(rd_qw), .rd_ack(rd_ack), .rd_tag(rd_tag),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_sof(rx_sof), .rx_eof(rx_eof),
        .committed_cons(cons), .committed_prod(committed_prod),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    // host memory contents, one word per dword address
    function automatic logic [31:0] host_dw(input logic [63:0] a);
        return {a[17:2], a[33:18]} ^ a[63:32] ^ 32'hc3a5_5a3c;
    endfunction

    function automatic int chunk_qw(input logic [2:0] c, input int rem);
        int mx;
        mx = (c == 3'd0) ? 16 : (c == 3'd1) ? 32 : (c == 3'd2) ? 64 : 128;
        return (rem < mx) ? rem : mx;
    endfunction

    task automatic record_issue(input logic [63:0] a, input int qw, input int t);
        ibuf_pkg::ibuf_ptr_t used;
        ibuf_pkg::ibuf_addr_t slot;
        used = iprod_m - cons;
        assert (qw == chunk_qw(cfg, desc_rem)) else begin
            $display("mismatch at %0t: rd_qw %0d, expected %0d",
                     $time, qw, chunk_qw(cfg, desc_rem));
            mism_cnt++;
        end
        assert (a === desc_addr_m) else begin
            $display("mismatch at %0t: hst_addr %h, expected %h", $time, a, desc_addr_m);
            mism_cnt++;
        end
        assert (int'(used) + qw <= 512) else begin
            $display("read issued without ring space at %0t", $time);
            fail_cnt++;
        end
        assert (os_tag.size() < `MAX_OS_REQ) else begin
            $display("too many outstanding reads at %0t", $time);
            fail_cnt++;
        end
        for (int k = 0; k < qw; k++) begin
            slot = iprod_m[8:0] + 9'(k);
            exp_mem[slot] = {host_dw(desc_addr_m + 8 * k + 4), host_dw(desc_addr_m + 8 * k)};
            pend[slot] = 1'b1;
        end
        os_tag.push_back(t);
        os_len.push_back(qw);
        os_base.push_back(int'(iprod_m[8:0]));
        busy[t] = 1'b1;
        c_addr[t] = desc_addr_m;
        c_rem[t] = 2 * qw;
        iprod_m = iprod_m + qw;
        desc_addr_m = desc_addr_m + 8 * qw;
        desc_rem = desc_rem - qw;
    endtask

    ////////////////////////////////////////
    // host model
    ////////////////////////////////////////
    always begin
        int t;
        int found;
        @(negedge clk);
        if (!rst && rd && !rd_ack) begin
            repeat ($unsigned($random(seed)) % 6) @(negedge clk);
            found = -1;
            while (found < 0) begin
                t = $unsigned($random(seed)) % 4;
                for (int i = 0; i < 4; i++) begin
                    if (found < 0 && !busy[(t + i) % 4] && (t + i) % 4 != shun_tag) begin
                        found = (t + i) % 4;
                    end
                end
                if (found < 0) begin
                    assert (shun_tag >= 0) else begin
                        $display("no free tag for a read at %0t", $time);
                        fail_cnt++;
                        found = 0;
                    end
                end
                if (found < 0) begin
                    @(negedge clk);     // only the stray tlp's tag is free
                end
            end
            record_issue(hst_addr, int'(rd_qw), found);
            rd_ack = 1'b1;
            rd_tag = found[1:0];
            @(negedge clk);
            assert (!rd) else begin
                $display("rd still high a cycle after rd_ack at %0t", $time);
                fail_cnt++;
            end
            while (rd) @(negedge clk);
            rd_ack = 1'b0;
        end
    end

    task automatic put_beat(input logic [63:0] d, input logic sof, input logic eof);
        rx_data = d;
        rx_valid = 1'b1;
        rx_sof = sof;
        rx_eof = eof;
    endtask

    task automatic send_tlp(input logic [6:0] fmt, input logic [2:0] st, input logic [7:0] tag8,
                            input int n, input logic [63:0] a, input bit good);
        logic [31:0] d [$];
        int i;
        for (int k = 0; k < n; k++) begin
            d.push_back(good ? host_dw(a + 4 * k) : 32'($random(seed)));
        end
        put_beat({16'h0, st, 1'b0, 12'(4 * n), 1'b0, fmt, 14'h0, 10'(n)}, 1'b1, 1'b0);
        @(negedge clk);
        put_beat({d[0], 16'h0, tag8, 8'h0}, 1'b0, n == 1);
        i = 1;
        while (i < n) begin
            @(negedge clk);
            if (($random(seed) & 3) == 0) begin
                rx_valid = 1'b0;    // gap
                @(negedge clk);
            end
            put_beat({(i + 1 < n) ? d[i + 1] : 32'h0, d[i]}, 1'b0, i + 2 >= n);
            i = i + 2;
        end
    endtask

    // completion sender, tags interleave only between tlps
    always begin
        int t;
        int pick;
        int n;
        @(negedge clk);
        rx_valid = 1'b0;
        rx_sof = 1'b0;
        rx_eof = 1'b0;
        shun_tag = -1;
        if (!rst) begin
            pick = -1;
            t = $unsigned($random(seed)) % 4;
            for (int i = 0; i < 4; i++) begin
                if (pick < 0 && busy[(t + i) % 4] && c_rem[(t + i) % 4] > 0) pick = (t + i) % 4;
            end
            n = 1 + $unsigned($random(seed)) % 6;
            case ($unsigned($random(seed)) % 24)
                0: send_tlp(7'b00_01010, `CPL_SC, 8'(t), n, 64'h0, 1'b0);       // no data type
                1: send_tlp(`CPL_FMT_TYPE, 3'b100, 8'(t), n, 64'h0, 1'b0);     // aborted
                2: begin
                    // a free tag if there is one, else a tag out of range
                    for (int i = 0; i < 4; i++) begin
                        if (shun_tag < 0 && !busy[(t + i) % 4]) shun_tag = (t + i) % 4;
                    end
                    send_tlp(`CPL_FMT_TYPE, `CPL_SC,
                             (shun_tag >= 0) ? 8'(shun_tag) : (8'h80 | 8'(t)),
                             n, 64'h0, 1'b0);
                end
                default: begin
                    if (pick >= 0) begin
                        n = 1 + $unsigned($random(seed)) % 12;
                        if (n > c_rem[pick]) n = c_rem[pick];
                        send_tlp(`CPL_FMT_TYPE, `CPL_SC, 8'(pick), n, c_addr[pick], 1'b1);
                        c_addr[pick] = c_addr[pick] + 4 * n;
                        c_rem[pick] = c_rem[pick] - n;
                    end
                end
            endcase
        end
    end

    // consumer drains the ring at random unless held
    always @(negedge clk) begin
        int diff;
        if (!rst && !hold && cons != committed_prod && ($random(seed) & 3) == 0) begin
            diff = int'(ibuf_pkg::ibuf_ptr_t'(committed_prod - cons));
            cons = cons + 1 + $unsigned($random(seed)) % diff;
        end
    end

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (!rst && wr_en) begin
            assert (pend[wr_addr]) else begin
                $display("write to slot %0d that awaits no data at %0t", wr_addr, $time);
                fail_cnt++;
            end
            assert (wr_data === exp_mem[wr_addr]) else begin
                $display("mismatch at %0t: slot %0d data %h, expected %h",
                         $time, wr_addr, wr_data, exp_mem[wr_addr]);
                mism_cnt++;
            end
            pend[wr_addr] = 1'b0;
        end
    end

    always @(negedge clk) begin
        int delta;
        if (!rst && committed_prod !== prod_seen) begin
            delta = int'(ibuf_pkg::ibuf_ptr_t'(committed_prod - prod_seen));
            if (os_tag.size() == 0) begin
                $display("producer pointer moved with no read outstanding at %0t", $time);
                fail_cnt++;
            end else begin
                assert (delta == os_len[0]) else begin
                    $display("mismatch at %0t: commit step %0d, expected %0d",
                             $time, delta, os_len[0]);
                    mism_cnt++;
                end
                for (int k = 0; k < os_len[0]; k++) begin
                    assert (!pend[(os_base[0] + k) % 512]) else begin
                        $display("commit covers unwritten slot at %0t", $time);
                        fail_cnt++;
                    end
                end
                busy[os_tag[0]] = 1'b0;
                void'(os_tag.pop_front());
                void'(os_len.pop_front());
                void'(os_base.pop_front());
            end
            prod_seen = committed_prod;
        end
    end

    initial begin
        wait (plan_ready);
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int d_len [NDESC];
        logic [63:0] d_addr [NDESC];
        longint total;
        cfg = 3'd0;
        lbuf_req = 1'b0;
        lbuf_addr = '0;
        lbuf_len = '0;
        rd_ack = 1'b0;
        rd_tag = '0;
        rx_data = '0;
        rx_valid = 1'b0;
        rx_sof = 1'b0;
        rx_eof = 1'b0;
        cons = '0;
        total = 0;
        for (int i = 0; i < NDESC; i++) begin
            d_len[i] = (i == 1) ? 700 : 1 + $unsigned($random(seed)) % 200;   // 700 fills the ring
            d_addr[i] = {32'($random(seed)), 32'($random(seed))} & ~64'h7;
            total += d_len[i];
        end
        limit_ns = (total * 60 + 8000) * 8;
        plan_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NDESC; i++) begin
            repeat ($unsigned($random(seed)) % 20) @(negedge clk);
            cfg = 3'($random(seed));
            desc_addr_m = d_addr[i];
            desc_rem = d_len[i];
            lbuf_addr = d_addr[i];
            lbuf_len = d_len[i];
            lbuf_req = 1'b1;
            if (i == 1) begin
                hold = 1'b1;
                fork
                    begin
                        repeat (1500) @(negedge clk);
                        hold = 1'b0;
                    end
                join_none
            end
            while (!lbuf_ack) @(negedge clk);
            assert (desc_rem == 0 && !rd && !rd_ack) else begin
                $display("lbuf_ack raised before the last read handshake closed at %0t", $time);
                fail_cnt++;
            end
            @(negedge clk);
            assert (lbuf_ack) else begin
                $display("lbuf_ack dropped while lbuf_req was high at %0t", $time);
                fail_cnt++;
            end
            lbuf_req = 1'b0;
            while (lbuf_ack) @(negedge clk);
        end
        while (os_tag.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/ibuf_pkg.sv
common/req_if.sv
common/cpl_stream_if.sv
source/rd_req_gen.sv
source/cpl_filter.sv
cpl_write/cpl_writer.sv
source/cpl_order.sv
source/ibuf_rx.sv
dv/tb_ibuf_rx.sv

// ==== Bender.yml ====
package:
  name: ibuf_rx

sources:
  - include_dirs:
      - common
    files:
      - common/ibuf_pkg.sv
      - common/req_if.sv
      - common/cpl_stream_if.sv
      - source/rd_req_gen.sv
      - source/cpl_filter.sv
      - cpl_write/cpl_writer.sv
      - source/cpl_order.sv
      - source/ibuf_rx.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/tb_ibuf_rx.sv
